// ==== flist.f ====
verilog/uart_pkg.sv
verilog/console_pkg.sv
verilog/uart_rx.sv
verilog/console_merge.sv
verilog/console_capture_top.sv
tests/console_capture_checker.sv
tests/console_capture_tb.sv

// ==== Bender.yml ====
package:
  name: console_capture

sources:
  # Packages first, then the receivers, merge stage and top level
  - files:
      - verilog/uart_pkg.sv
      - verilog/console_pkg.sv
      - verilog/uart_rx.sv
      - verilog/console_merge.sv
      - verilog/console_capture_top.sv

  - target: test
    files:
      - tests/console_capture_checker.sv
      - tests/console_capture_tb.sv

// ==== tests/console_capture_tb.sv ====
module console_capture_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;
    import console_pkg::*;

    localparam int frame_limit = 12 * clks_per_bit; // Cycles allowed for one frame to come out

    logic  clk;
    logic  rst;
    logic  rxd_0;
    logic  rxd_1;
    logic  char_valid;
    char_t char_data;
    chan_t char_chan;
    logic  char_printable;
    logic  frame_err_0;
    logic  frame_err_1;

    console_capture_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .rxd_0          (rxd_0),
        .rxd_1          (rxd_1),
        .char_valid     (char_valid),
        .char_data      (char_data),
        .char_chan      (char_chan),
        .char_printable (char_printable),
        .frame_err_0    (frame_err_0),
        .frame_err_1    (frame_err_1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Assertion failures in the bound checker end the run right away
    always @(u_dut.u_chk.fail_count) begin
        if (u_dut.u_chk.fail_count != 0) begin
            $display("An assertion in the bound checker failed");
            abort_run();
        end
    end

    task automatic cmp_char(input string name, input char_t got, input char_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic cmp_chan(input string name, input chan_t got, input chan_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic cmp_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Printable ASCII is space through tilde
    function automatic logic is_printable(input char_t c);
        return (c >= 8'd32) && (c <= 8'd126);
    endfunction

    task automatic drive_line(input int line, input logic level);
        if (line == 0) begin
            rxd_0 = level;
        end else begin
            rxd_1 = level;
        end
    endtask

    // Start bit, LSB first payload, then stop bit
    task automatic send_frame(input int line, input char_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            drive_line(line, frame[i]);
            repeat (clks_per_bit) @(negedge clk);
        end
        drive_line(line, 1'b1); // Back to idle
    endtask

    task automatic wait_char(input int limit);
        int n;
        n = 0;
        while (char_valid !== 1'b1) begin
            if (n == limit) begin
                $display("No character arrived within %0d clock cycles", limit);
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_err_1(input int limit);
        int n;
        n = 0;
        while (frame_err_1 !== 1'b1) begin
            if (n == limit) begin
                $display("No framing error on line 1 within %0d clock cycles", limit);
                abort_run();
            end
            if (char_valid === 1'b1) begin
                $display("A character came out of a frame with a low stop bit");
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_char(input char_t exp_data, input chan_t exp_chan);
        cmp_char("char_data", char_data, exp_data);
        cmp_chan("char_chan", char_chan, exp_chan);
        cmp_bit("char_printable", char_printable, is_printable(exp_data));
    endtask

    task automatic test_letter_line_0();
        fork
            send_frame(0, 8'h41, 1'b1);
            begin
                wait_char(frame_limit);
                check_char(8'h41, chan_t'(0));
                @(negedge clk);
                cmp_bit("char_valid", char_valid, 1'b0); // Single-cycle strobe
            end
        join
    endtask

    task automatic test_bell_line_1();
        fork
            send_frame(1, 8'h07, 1'b1);
            begin
                wait_char(frame_limit);
                check_char(8'h07, chan_t'(1));
            end
        join
    endtask

    task automatic test_both_lines();
        fork
            send_frame(0, 8'h55, 1'b1);
            send_frame(1, 8'h2A, 1'b1);
            begin
                wait_char(frame_limit);
                check_char(8'h55, chan_t'(0));
                @(negedge clk);
                cmp_bit("char_valid", char_valid, 1'b1); // Channel 1 right behind
                check_char(8'h2A, chan_t'(1));
            end
        join
    endtask

    task automatic test_cr_dropped();
        fork
            begin
                send_frame(0, 8'h0D, 1'b1);
                send_frame(0, 8'h0A, 1'b1);
            end
            begin
                wait_char(2 * frame_limit);
                check_char(8'h0A, chan_t'(0)); // First thing out must be the LF
            end
        join
    endtask

    task automatic test_frame_error();
        fork
            send_frame(1, 8'h5A, 1'b0);
            begin
                wait_err_1(frame_limit);
                cmp_bit("frame_err_0", frame_err_0, 1'b0);
                @(negedge clk);
                cmp_bit("frame_err_1", frame_err_1, 1'b0);
            end
        join
        repeat (2 * clks_per_bit) begin
            @(negedge clk);
            cmp_bit("char_valid", char_valid, 1'b0);
        end
    endtask

    task automatic test_random_bytes();
        char_t c;
        int    line;
        for (int i = 0; i < 20; i++) begin
            do begin
                c = char_t'($urandom);
            end while (c == 8'h0D);
            line = i % 2;
            fork
                send_frame(line, c, 1'b1);
                begin
                    wait_char(frame_limit);
                    check_char(c, chan_t'(line));
                end
            join
        end
    endtask

    initial begin
        void'($urandom(75163));
        rst   = 1'b1;
        rxd_0 = 1'b1;
        rxd_1 = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (2 * clks_per_bit) @(negedge clk);

        test_letter_line_0();
        test_bell_line_1();
        test_both_lines();
        test_cr_dropped();
        test_frame_error();
        test_random_bytes();
        repeat (clks_per_bit) @(negedge clk);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tests/console_capture_checker.sv ====
module console_capture_checker (
    input logic               clk,
    input logic               rst,
    input logic               char_valid,
    input console_pkg::char_t char_data,
    input console_pkg::chan_t char_chan,
    input logic               frame_err_0,
    input logic               frame_err_1
);

    timeunit 1ns;
    timeprecision 1ps;

    import console_pkg::*;

    int unsigned fail_count = 0;

    // Back-to-back strobes only when the channel switches
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
        char_valid |=> !char_valid || (char_chan != $past(char_chan)))
    else begin
        fail_count++;
        $error("char_valid high twice in a row on the same channel");
    end

    a_no_cr: assert property (@(posedge clk) disable iff (rst)
        char_valid |-> char_data != char_cr)
    else begin
        fail_count++;
        $error("carriage return reached the output");
    end

    // Strobes quiet once reset has been seen
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !char_valid && !frame_err_0 && !frame_err_1)
    else begin
        fail_count++;
        $error("output strobe high during reset");
    end

endmodule

bind console_capture_top console_capture_checker u_chk (.*);

// ==== verilog/console_capture_top.sv ====
module console_capture_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                rxd_0,
    input  logic                rxd_1,
    output logic                char_valid,
    output console_pkg::char_t  char_data,
    output console_pkg::chan_t  char_chan,
    output logic                char_printable,
    output logic                frame_err_0,
    output logic                frame_err_1
);

    import console_pkg::*;

    logic  rx_valid_0;
    char_t rx_data_0;
    logic  rx_err_0;
    logic  rx_valid_1;
    char_t rx_data_1;
    logic  rx_err_1;

    // Console of core 0
    uart_rx u_rx_0 (
        .clk        (clk),
        .rst        (rst),
        .rxd        (rxd_0),
        .byte_valid (rx_valid_0),
        .byte_data  (rx_data_0),
        .frame_err  (rx_err_0)
    );

    // Console of core 1
    uart_rx u_rx_1 (
        .clk        (clk),
        .rst        (rst),
        .rxd        (rxd_1),
        .byte_valid (rx_valid_1),
        .byte_data  (rx_data_1),
        .frame_err  (rx_err_1)
    );

    console_merge u_merge (
        .clk            (clk),
        .rst            (rst),
        .byte_valid_0   (rx_valid_0),
        .byte_data_0    (rx_data_0),
        .frame_err_0_in (rx_err_0),
        .byte_valid_1   (rx_valid_1),
        .byte_data_1    (rx_data_1),
        .frame_err_1_in (rx_err_1),
        .char_valid     (char_valid),
        .char_data      (char_data),
        .char_chan      (char_chan),
        .char_printable (char_printable),
        .frame_err_0    (frame_err_0),
        .frame_err_1    (frame_err_1)
    );

endmodule

// ==== verilog/console_merge.sv ====
module console_merge (
    input  logic                clk,
    input  logic                rst,
    input  logic                byte_valid_0,
    input  console_pkg::char_t  byte_data_0,
    input  logic                frame_err_0_in,
    input  logic                byte_valid_1,
    input  console_pkg::char_t  byte_data_1,
    input  logic                frame_err_1_in,
    output logic                char_valid,
    output console_pkg::char_t  char_data,
    output console_pkg::chan_t  char_chan,
    output logic                char_printable,
    output logic                frame_err_0,
    output logic                frame_err_1
);

    import console_pkg::*;

    logic [num_chan-1:0] in_valid;
    char_t               in_data   [num_chan];
    logic [num_chan-1:0] hold_valid;
    char_t               hold_data [num_chan];
    logic [num_chan-1:0] pend_valid;
    char_t               pend_data [num_chan];
    logic [num_chan-1:0] taken;
    logic [num_chan-1:0] load;
    logic                any_pend;
    chan_t               sel;
    char_t               sel_data;

    assign in_valid   = {byte_valid_1, byte_valid_0};
    assign in_data[0] = byte_data_0;
    assign in_data[1] = byte_data_1;

    // A fresh strobe counts as pending in its own cycle
    always_comb begin
        for (int c = 0; c < num_chan; c++) begin
            pend_valid[c] = hold_valid[c] | in_valid[c];
            pend_data[c]  = hold_valid[c] ? hold_data[c] : in_data[c];
        end
    end

    // Fixed priority, channel 0 wins
    assign any_pend = |pend_valid;
    assign sel      = pend_valid[0] ? chan_t'(0) : chan_t'(1);
    assign sel_data = pend_data[sel];

    always_comb begin
        for (int c = 0; c < num_chan; c++) begin
            taken[c] = any_pend && (sel == chan_t'(c));
            // Park the incoming byte unless it goes straight out
            load[c]  = in_valid[c] && !(taken[c] && !hold_valid[c]);
        end
    end

    // One-entry holding register per channel
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= '0;
        end else begin
            hold_valid <= load | (hold_valid & ~taken);
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < num_chan; c++) begin
            if (load[c]) begin
                hold_data[c] <= in_data[c];
            end
        end
    end

    // Output stage, CR is consumed without a strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            char_valid <= 1'b0;
        end else begin
            char_valid <= any_pend && (sel_data != char_cr);
        end
    end

    always_ff @(posedge clk) begin
        char_data      <= sel_data;
        char_chan      <= sel;
        char_printable <= (sel_data >= print_lo) && (sel_data <= print_hi);
    end

    // Error strobes delayed to match the character path
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_err_0 <= 1'b0;
            frame_err_1 <= 1'b0;
        end else begin
            frame_err_0 <= frame_err_0_in;
            frame_err_1 <= frame_err_1_in;
        end
    end

endmodule

// ==== verilog/uart_rx.sv ====
module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                rxd,
    output logic                byte_valid,
    output console_pkg::char_t  byte_data,
    output logic                frame_err
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t                 state;
    logic [sync_stages-1:0] rxd_sync;
    logic                   rxd_s;
    logic                   rxd_prev;
    logic                   start_edge;
    logic [baud_cnt_w-1:0]  baud_cnt;
    logic                   baud_tick;
    logic [bit_cnt_w-1:0]   bit_cnt;
    logic [data_bits-1:0]   shreg;

    assign rxd_s      = rxd_sync[sync_stages-1];
    assign start_edge = rxd_prev & ~rxd_s; // Falling edge on synced line
    assign baud_tick  = (baud_cnt == '0);  // Mid-bit sample point

    // Synchronizer and edge history, idle level is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_sync <= '1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[sync_stages-2:0], rxd};
            rxd_prev <= rxd_s;
        end
    end

    // Frame FSM with baud and bit counters
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;

            if (state == st_idle) begin
                if (start_edge) begin
                    state    <= st_start;
                    baud_cnt <= baud_cnt_w'(half_bit - 1); // First sample mid start bit
                end
            end else if (!baud_tick) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= baud_cnt_w'(clks_per_bit - 1);
                case (state)
                    st_start: begin
                        // Glitch shorter than half a bit gets ignored
                        if (!rxd_s) begin
                            state   <= st_data;
                            bit_cnt <= '0;
                        end else begin
                            state <= st_idle;
                        end
                    end
                    st_data: begin
                        if (bit_cnt == bit_cnt_w'(data_bits - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    st_stop: begin
                        state      <= st_idle; // Ready for next edge mid stop bit
                        byte_valid <= rxd_s;
                        frame_err  <= ~rxd_s;  // Low stop bit, byte is thrown away
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // Payload shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == st_data && baud_tick) begin
            shreg <= {rxd_s, shreg[data_bits-1:1]};
        end
    end

    assign byte_data = shreg; // Only qualified by byte_valid

endmodule

// ==== verilog/console_pkg.sv ====
package console_pkg;

    // Number of serial consoles merged into one stream
    localparam int num_chan = 2;

    // Channel tag carried with every character
    typedef logic [$clog2(num_chan)-1:0] chan_t;

    // One received character
    typedef logic [7:0] char_t;

    // Control codes seen in console output
    localparam char_t char_cr = 8'h0D; // Dropped by the merge stage
    localparam char_t char_lf = 8'h0A; // Kept as the bare line break

    // Printable ASCII range, both ends inclusive
    localparam char_t print_lo = 8'h20;
    localparam char_t print_hi = 8'h7E;

endpackage

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

    // Fixed line rate, given as clock cycles per serial bit
    localparam int clks_per_bit = 16;

    // Offset from the detected start edge to the middle of the start bit
    localparam int half_bit = clks_per_bit / 2;

    // 8N1 frame: one start bit, data_bits payload bits, one stop bit
    localparam int data_bits = 8;

    // Flops in front of the edge detector on the asynchronous line
    localparam int sync_stages = 2;

    // Counter widths derived from the timing above
    localparam int baud_cnt_w = $clog2(clks_per_bit);
    localparam int bit_cnt_w  = $clog2(data_bits);

endpackage
